// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := dot_engine_tb
FILELIST  := list.f
OBJ_DIR   := obj_dir
LOG       := sim.log
SIM_ARGS  := +verilator+error+limit+100

SRCS := $(shell grep -v '^+' $(FILELIST)) $(wildcard hdl/*.svh)

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	-./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) | tee $(LOG)
	@if grep -q "^TESTBENCH PASSED$$" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== bench/dot_engine_assertions.sv ====
module dot_engine_assertions (
    input logic clk,
    input logic rst_n,
    input logic req0,
    input logic req1,
    input logic gnt0,
    input logic gnt1,
    input logic prod_valid
);

    int fail_count = 0;

    grant_exclusive: assert property (@(posedge clk) disable iff (!rst_n) !(gnt0 && gnt1))
        else begin
            $error("gnt0 and gnt1 high in the same cycle");
            fail_count++;
        end

    // Two pipeline stages between a grant and its product
    product_latency: assert property (@(posedge clk) disable iff (!rst_n)
        $past(rst_n, 2) |-> (prod_valid == $past(gnt0 || gnt1, 2)))
        else begin
            $error("prod_valid does not follow a grant by two cycles");
            fail_count++;
        end

    refused_gets_turn_0: assert property (@(posedge clk) disable iff (!rst_n)
        (req0 && !gnt0) |=> gnt0)
        else begin
            $error("Channel 0 refused and not granted in the next cycle");
            fail_count++;
        end

    refused_gets_turn_1: assert property (@(posedge clk) disable iff (!rst_n)
        (req1 && !gnt1) |=> gnt1)
        else begin
            $error("Channel 1 refused and not granted in the next cycle");
            fail_count++;
        end

endmodule

bind mult_arbiter dot_engine_assertions arb_chk_i (
    .clk(clk), .rst_n(rst_n), .req0(req0), .req1(req1),
    .gnt0(gnt0), .gnt1(gnt1), .prod_valid(prod_valid)
);

// ==== bench/dot_engine_tb.sv ====
module dot_engine_tb import amul_pkg::*; ();

    localparam int N_RAND_RUNS = 10;
    localparam int N_DUAL_RUNS = 8;
    localparam int MAX_LEN     = 16;
    localparam int PART_LEN    = 6;
    localparam int MAX_ITEMS   = 26 + (N_RAND_RUNS + 2 * N_DUAL_RUNS + 2) * MAX_LEN + 2 * PART_LEN;
    localparam int LIMIT       = MAX_ITEMS * 8 + 200;

    // One word per column term of the low rows
    // [31:24] column, [23:20] op (0 xor, 1 and, 2 single bit, 3 constant one),
    // [19:16] first row, [15:12] its bit, [11:8] second row, [7:4] its bit
    localparam logic [27:0][31:0] CORR_TAB = {
        32'h0200_2110, 32'h0402_2310, 32'h0600_6150, 32'h0710_6150, 32'h0814_3520,
        32'h0A14_5540, 32'h0B00_B1A0, 32'h0C02_A390, 32'h0E00_E1D0, 32'h0F12_C3B0,
        32'h1030_0000, 32'h1121_F000, 32'h1212_F3E0, 32'h1314_E5D0, 32'h1414_F5E0,
        32'h0804_4530, 32'h0B02_9380, 32'h0C14_7560, 32'h0F14_A590, 32'h1004_C5B0,
        32'h1112_E3D0, 32'h1223_F000, 32'h1304_F5E0, 32'h1425_F000, 32'h1102_F3E0,
        32'h1214_D5C0, 32'h1104_C5B0, 32'h1204_E5D0
    };

    localparam logic [4:0][15:0] CORNERS = {16'h0000, 16'h0001, 16'hFFFF, 16'h7FFF, 16'h8000};

    logic           clk;
    logic           rst_n;
    logic           rst_req;
    logic     [1:0] in_valid;
    logic     [1:0] in_last;
    operand_t [1:0] in_a;
    operand_t [1:0] in_b;
    logic     [1:0] dot_valid;
    acc_t     [1:0] dot_sum;

    logic [32:0] stim0 [$]; // {last, a, b} per item
    logic [32:0] stim1 [$];
    acc_t        exp_q0 [$];
    acc_t        exp_q1 [$];
    int          checks = 0;
    int          errors = 0;
    int          err_mark = 0;

    tb_clock_gen clk_gen_i (.rst_req(rst_req), .clk(clk), .rst_n(rst_n));

    dot_engine_top dut_i (
        .clk(clk), .rst_n(rst_n),
        .in_valid_0(in_valid[0]), .in_a_0(in_a[0]), .in_b_0(in_b[0]), .in_last_0(in_last[0]),
        .dot_valid_0(dot_valid[0]), .dot_sum_0(dot_sum[0]),
        .in_valid_1(in_valid[1]), .in_a_1(in_a[1]), .in_b_1(in_b[1]), .in_last_1(in_last[1]),
        .dot_valid_1(dot_valid[1]), .dot_sum_1(dot_sum[1])
    );

    // ************************************************************
    // Reference model
    // ************************************************************

    // Baugh-Wooley bit that is inverted when exactly one factor is a sign bit
    function automatic logic pp_bit(input operand_t x, input operand_t y, input int i,
                                    input int j);
        logic b;
        b = x[i] & y[j];
        if ((i == 15) != (j == 15))
            b = ~b;
        return b;
    endfunction

    function automatic product_t approx_product(input operand_t x, input operand_t y);
        logic [31:0] s;
        logic [31:0] e;
        logic        t;
        s = 32'h8000_0000; // Constant one of the sign row
        for (int i = 6; i < 16; i++) begin
            for (int j = 0; j < 16; j++) begin
                s += 32'(pp_bit(x, y, i, j)) << (i + j);
            end
        end
        for (int k = 0; k < 28; k++) begin
            e = CORR_TAB[k];
            case (e[23:20])
                4'd0: t = pp_bit(x, y, int'(e[19:16]), int'(e[15:12]))
                        ^ pp_bit(x, y, int'(e[11:8]), int'(e[7:4]));
                4'd1: t = pp_bit(x, y, int'(e[19:16]), int'(e[15:12]))
                        & pp_bit(x, y, int'(e[11:8]), int'(e[7:4]));
                4'd2: t = pp_bit(x, y, int'(e[19:16]), int'(e[15:12]));
                default: t = 1'b1;
            endcase
            s += 32'(t) << e[31:24];
        end
        return product_t'(s);
    endfunction

    function automatic acc_t expected_dot(input operand_t a [$], input operand_t b [$]);
        acc_t s;
        s = '0;
        foreach (a[k])
            s += acc_t'(approx_product(a[k], b[k]));
        return s;
    endfunction

    // ************************************************************
    // Stimulus
    // ************************************************************

    task automatic add_run(input int ch, input operand_t a [$], input operand_t b [$],
                           input bit partial);
        logic [32:0] w;
        foreach (a[k]) begin
            w = {(k == a.size() - 1) && !partial, a[k], b[k]};
            if (ch == 0)
                stim0.push_back(w);
            else
                stim1.push_back(w);
        end
        if (!partial) begin
            if (ch == 0)
                exp_q0.push_back(expected_dot(a, b));
            else
                exp_q1.push_back(expected_dot(a, b));
        end
    endtask

    task automatic random_run(input int ch, input int n, input bit partial);
        operand_t a [$];
        operand_t b [$];
        repeat (n) begin
            a.push_back(operand_t'($urandom));
            b.push_back(operand_t'($urandom));
        end
        add_run(ch, a, b, partial);
    endtask

    task automatic drive_stream(input int ch, input logic [32:0] s [$]);
        foreach (s[k]) begin
            @(posedge clk);
            in_valid[ch] <= 1'b1;
            {in_last[ch], in_a[ch], in_b[ch]} <= s[k];
            @(posedge clk);
            in_valid[ch] <= 1'b0; // Fastest allowed rate of one strobe per two cycles
        end
    endtask

    task automatic run_streams();
        fork
            drive_stream(0, stim0);
            drive_stream(1, stim1);
        join
        stim0.delete();
        stim1.delete();
        while (exp_q0.size() != 0 || exp_q1.size() != 0)
            @(posedge clk);
    endtask

    task automatic end_test(input string name);
        $display("%s: %0d errors", name, errors - err_mark);
        err_mark = errors;
    endtask

    // ************************************************************
    // Compare
    // ************************************************************

    task automatic check_sum(input int ch, input acc_t got);
        acc_t want;
        int   pending;
        pending = (ch == 0) ? exp_q0.size() : exp_q1.size();
        assert (pending != 0) else begin
            $display("Channel %0d reported a sum while no run was outstanding", ch);
            errors++;
        end
        if (pending != 0) begin
            if (ch == 0)
                want = exp_q0.pop_front();
            else
                want = exp_q1.pop_front();
            checks++;
            assert (got == want) else begin
                $display("Fail dot_sum_%0d: got %h, expected %h", ch, got, want);
                errors++;
            end
        end
    endtask

    always @(negedge clk) begin
        if (rst_n) begin
            for (int c = 0; c < 2; c++) begin
                if (dot_valid[c])
                    check_sum(c, dot_sum[c]);
            end
        end
    end

    initial begin
        operand_t a [$];
        operand_t b [$];
        int       assert_fails;
        in_valid <= 2'b00;
        in_last  <= 2'b00;
        in_a     <= '0;
        in_b     <= '0;
        rst_req  <= 1'b0;
        void'($urandom(53708));
        while (rst_n !== 1'b1)
            @(posedge clk);

        repeat (10) begin
            @(negedge clk);
            assert (dot_valid == 2'b00) else begin
                $display("Fail dot_valid: got %h, expected %h", dot_valid, 2'b00);
                errors++;
            end
        end
        random_run(0, 1, 1'b0);
        run_streams();
        end_test("Test 1 idle and single item");

        for (int i = 0; i < 5; i++) begin
            for (int j = 0; j < 5; j++) begin
                a.delete();
                b.delete();
                a.push_back(CORNERS[i]);
                b.push_back(CORNERS[j]);
                add_run(0, a, b, 1'b0);
            end
        end
        run_streams();
        end_test("Test 2 corner operands");

        repeat (N_RAND_RUNS)
            random_run(0, $urandom_range(MAX_LEN, 1), 1'b0);
        run_streams();
        end_test("Test 3 random runs on channel 0");

        repeat (N_DUAL_RUNS) begin
            random_run(0, $urandom_range(MAX_LEN, 1), 1'b0);
            random_run(1, $urandom_range(MAX_LEN, 1), 1'b0);
        end
        run_streams();
        end_test("Test 4 both channels at full rate");

        // Open runs with items still queued and in the pipeline when reset hits
        random_run(0, PART_LEN, 1'b1);
        random_run(1, PART_LEN, 1'b1);
        run_streams();
        rst_req <= 1'b1;
        repeat (2) @(posedge clk);
        rst_req <= 1'b0;
        random_run(0, $urandom_range(MAX_LEN, 1), 1'b0);
        random_run(1, $urandom_range(MAX_LEN, 1), 1'b0);
        run_streams();
        end_test("Test 5 reset in the middle of a run");

        assert_fails = dut_i.arb_i.arb_chk_i.fail_count;
        errors += assert_fails;
        $display("Summary: %0d checks, %0d errors, %0d assertion failures",
                 checks, errors, assert_fails);
        if (errors == 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin
        repeat (LIMIT) @(posedge clk);
        $display("Timeout: the tests did not finish within %0d cycles", LIMIT);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

// ==== bench/tb_clock_gen.sv ====
module tb_clock_gen (
    input  logic rst_req,
    output logic clk,
    output logic rst_n
);

    logic por_n;

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk; // Period of 40
    end

    // Power-on reset covers the first two rising edges
    initial begin
        por_n <= 1'b0;
        repeat (2) @(posedge clk);
        por_n <= 1'b1;
    end

    assign rst_n = por_n & ~rst_req; // The test can pull reset again at any edge

endmodule

// ==== hdl/amul_consts.svh ====
`ifndef AMUL_CONSTS_SVH
`define AMUL_CONSTS_SVH

// ***********************************************************
// Datapath widths
// ***********************************************************

// Multiplier operand width, the approximation table is built for 16 only
`define AMUL_OP_W 16

// Room for 256 full-scale products before the sum wraps
`define AMUL_ACC_W 40

// ***********************************************************
// Channel sizing
// ***********************************************************

`define AMUL_Q_DEPTH 2 // Enough for one strobe per two cycles
`define AMUL_CNT_W 8

`endif

// ==== hdl/amul_pkg.sv ====
`include "amul_consts.svh"

package amul_pkg;

    // Operands and products are two's complement
    typedef logic signed [`AMUL_OP_W-1:0] operand_t;
    typedef logic signed [2*`AMUL_OP_W-1:0] product_t;

    typedef logic signed [`AMUL_ACC_W-1:0] acc_t;

    typedef logic [0:0] chan_id_t; // Index of one of the two channels

    // IDLE holds an empty sum, ACCUM a partial one, FLUSH reports the result
    typedef enum logic [1:0] {
        IDLE,
        ACCUM,
        FLUSH
    } chan_state_t;

endpackage

// ==== hdl/approx_mult_16x16.sv ====
module approx_mult_16x16 import amul_pkg::*; (
    input  operand_t x,
    input  operand_t y,
    output product_t z
);

    // Baugh-Wooley rows, row i belongs to multiplier bit x[i]
    logic [15:0] row [16];

    // Sparse column terms that stand in for rows 0 to 5
    logic [20:0] corr_a;
    logic [20:0] corr_b;
    logic [20:0] corr_c;
    logic [20:0] corr_d;

    logic [31:0] sum;

    always_comb begin
        for (int i = 0; i < 15; i++) begin
            row[i][14:0] = y[14:0] & {15{x[i]}};
            row[i][15]   = ~(y[15] & x[i]); // Inverted sign term
        end
        // The sign row of x is inverted except for the sign-by-sign bit
        row[15][14:0] = ~(y[14:0] & {15{x[15]}});
        row[15][15]   = y[15] & x[15];
    end

    // ***********************************************************
    // Correction table for the low rows
    // ***********************************************************

    always_comb begin
        corr_a     = '0;
        corr_a[2]  = row[0][2] ^ row[1][1];
        corr_a[4]  = row[2][2] ^ row[3][1];
        corr_a[6]  = row[0][6] ^ row[1][5];
        corr_a[7]  = row[0][6] & row[1][5];
        corr_a[8]  = row[4][3] & row[5][2];
        corr_a[10] = row[4][5] & row[5][4];
        corr_a[11] = row[0][11] ^ row[1][10];
        corr_a[12] = row[2][10] ^ row[3][9];
        corr_a[14] = row[0][14] ^ row[1][13];
        corr_a[15] = row[2][12] & row[3][11];
        corr_a[16] = 1'b1;                  // Constant correction bit
        corr_a[17] = row[1][15];
        corr_a[18] = row[2][15] & row[3][14];
        corr_a[19] = row[4][14] & row[5][13];
        corr_a[20] = row[4][15] & row[5][14];
    end

    always_comb begin
        corr_b     = '0;
        corr_b[8]  = row[4][4] ^ row[5][3];
        corr_b[11] = row[2][9] ^ row[3][8];
        corr_b[12] = row[4][7] & row[5][6];
        corr_b[15] = row[4][10] & row[5][9];
        corr_b[16] = row[4][12] ^ row[5][11];
        corr_b[17] = row[2][14] & row[3][13];
        corr_b[18] = row[3][15];
        corr_b[19] = row[4][15] ^ row[5][14];
        corr_b[20] = row[5][15];
    end

    // The last two vectors only touch the columns near the top of the low rows
    always_comb begin
        corr_c     = '0;
        corr_c[17] = row[2][15] ^ row[3][14];
        corr_c[18] = row[4][13] & row[5][12];
    end

    always_comb begin
        corr_d     = '0;
        corr_d[17] = row[4][12] ^ row[5][11];
        corr_d[18] = row[4][14] ^ row[5][13];
    end

    // ***********************************************************
    // Final sum
    // ***********************************************************

    always_comb begin
        sum = 32'h0;
        for (int i = 6; i < 15; i++) begin
            sum = sum + (32'(row[i]) << i); // Exact rows
        end
        sum = sum + (32'({1'b1, row[15]}) << 15);
        sum = sum + 32'(corr_a) + 32'(corr_b) + 32'(corr_c) + 32'(corr_d);
    end

    assign z = product_t'(sum); // Wraps modulo 2^32 like the plain adder tree

endmodule

// ==== hdl/dot_engine_top.sv ====
module dot_engine_top import amul_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     in_valid_0,
    input  operand_t in_a_0,
    input  operand_t in_b_0,
    input  logic     in_last_0,
    output logic     dot_valid_0,
    output acc_t     dot_sum_0,
    input  logic     in_valid_1,
    input  operand_t in_a_1,
    input  operand_t in_b_1,
    input  logic     in_last_1,
    output logic     dot_valid_1,
    output acc_t     dot_sum_1
);

    logic     req0;
    operand_t req_a0;
    operand_t req_b0;
    logic     gnt0;
    logic     req1;
    operand_t req_a1;
    operand_t req_b1;
    logic     gnt1;

    // Shared product bus, each channel picks its own tag
    logic     prod_valid;
    chan_id_t prod_id;
    product_t prod;

    mac_channel #(.chan_index(1'b0)) chan0_i (
        .clk(clk), .rst_n(rst_n),
        .in_valid(in_valid_0), .in_a(in_a_0), .in_b(in_b_0), .in_last(in_last_0),
        .req(req0), .req_a(req_a0), .req_b(req_b0), .gnt(gnt0),
        .prod_valid(prod_valid), .prod_id(prod_id), .prod(prod),
        .dot_valid(dot_valid_0), .dot_sum(dot_sum_0)
    );

    mac_channel #(.chan_index(1'b1)) chan1_i (
        .clk(clk), .rst_n(rst_n),
        .in_valid(in_valid_1), .in_a(in_a_1), .in_b(in_b_1), .in_last(in_last_1),
        .req(req1), .req_a(req_a1), .req_b(req_b1), .gnt(gnt1),
        .prod_valid(prod_valid), .prod_id(prod_id), .prod(prod),
        .dot_valid(dot_valid_1), .dot_sum(dot_sum_1)
    );

    mult_arbiter arb_i (
        .clk(clk), .rst_n(rst_n),
        .req0(req0), .req_a0(req_a0), .req_b0(req_b0), .gnt0(gnt0),
        .req1(req1), .req_a1(req_a1), .req_b1(req_b1), .gnt1(gnt1),
        .prod_valid(prod_valid), .prod_id(prod_id), .prod(prod)
    );

endmodule

// ==== hdl/mac_channel.sv ====
`include "amul_consts.svh"

module mac_channel import amul_pkg::*; #(
    parameter chan_id_t chan_index = 1'b0
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     in_valid,
    input  operand_t in_a,
    input  operand_t in_b,
    input  logic     in_last,
    output logic     req,
    output operand_t req_a,
    output operand_t req_b,
    input  logic     gnt,
    input  logic     prod_valid,
    input  chan_id_t prod_id,
    input  product_t prod,
    output logic     dot_valid,
    output acc_t     dot_sum
);

    localparam int DEPTH = `AMUL_Q_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    // ***********************************************************
    // Operand queue
    // ***********************************************************

    operand_t   q_a    [DEPTH];
    operand_t   q_b    [DEPTH];
    logic       q_last [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    // Last flags of granted items, aligned with the two arbiter stages
    logic [1:0] fl_last;

    logic        my_prod;
    chan_state_t state;
    acc_t        acc;
    acc_t        acc_base;

    always_ff @(posedge clk) begin
        if (in_valid) begin
            q_a[wr_ptr]    <= in_a;
            q_b[wr_ptr]    <= in_b;
            q_last[wr_ptr] <= in_last;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (in_valid) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (gnt) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CNT_W'(in_valid) - CNT_W'(gnt);
        end
    end

    assign req   = (count != '0);
    assign req_a = q_a[rd_ptr];
    assign req_b = q_b[rd_ptr];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fl_last <= 2'b00;
        end else begin
            fl_last <= {fl_last[0], gnt & q_last[rd_ptr]};
        end
    end

    // ***********************************************************
    // Accumulator
    // ***********************************************************

    assign my_prod  = prod_valid && (prod_id == chan_index);
    assign acc_base = (state == FLUSH) ? '0 : acc; // The reported sum is dropped

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= IDLE;
            acc   <= '0;
        end else if (my_prod) begin
            acc   <= acc_base + acc_t'(prod); // Sign-extends the product
            state <= fl_last[1] ? FLUSH : ACCUM;
        end else begin
            acc <= acc_base;
            if (state == FLUSH) begin
                state <= IDLE;
            end
        end
    end

    assign dot_valid = (state == FLUSH);
    assign dot_sum   = acc;

endmodule

// ==== hdl/mult_arbiter.sv ====
module mult_arbiter import amul_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     req0,
    input  operand_t req_a0,
    input  operand_t req_b0,
    output logic     gnt0,
    input  logic     req1,
    input  operand_t req_a1,
    input  operand_t req_b1,
    output logic     gnt1,
    output logic     prod_valid,
    output chan_id_t prod_id,
    output product_t prod
);

    chan_id_t last_gnt;

    // Operand stage in front of the multiplier
    logic     s1_valid;
    chan_id_t s1_id;
    operand_t s1_a;
    operand_t s1_b;

    product_t mult_z;

    // Channel 0 wins unless both request and it was served last
    assign gnt0 = req0 & (~req1 | (last_gnt == 1'b1));
    assign gnt1 = req1 & ~gnt0;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            last_gnt <= 1'b1; // Gives channel 0 the first turn
        end else if (gnt0 | gnt1) begin
            last_gnt <= gnt1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= gnt0 | gnt1;
        end
    end

    always_ff @(posedge clk) begin
        s1_id <= gnt1;
        s1_a  <= gnt1 ? req_a1 : req_a0;
        s1_b  <= gnt1 ? req_b1 : req_b0;
    end

    approx_mult_16x16 mult_i (
        .x (s1_a),
        .y (s1_b),
        .z (mult_z)
    );

    // Product stage, the tag travels with the result
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            prod_valid <= 1'b0;
        end else begin
            prod_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        prod_id <= s1_id;
        prod    <= mult_z;
    end

endmodule

// ==== list.f ====
+incdir+hdl
hdl/amul_pkg.sv
hdl/approx_mult_16x16.sv
hdl/mult_arbiter.sv
hdl/mac_channel.sv
hdl/dot_engine_top.sv
bench/tb_clock_gen.sv
bench/dot_engine_assertions.sv
bench/dot_engine_tb.sv
